//--- hdl/link_pkg.sv
`default_nettype none

package link_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // link data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;   // one byte on the PC link
    typedef logic [63:0] word_t;   // experiment parameter

    ////////////////////////////////////////////////////////////////////////////
    // frame layout
    ////////////////////////////////////////////////////////////////////////////

    // sync pair that opens every frame
    localparam byte_t SYNC_HI = 8'h00;
    localparam byte_t SYNC_LO = 8'hFF;

    localparam int HDR_BYTES  = 3;   // sync pair plus code byte
    localparam int WORD_BYTES = 8;   // payload sent msb first

    ////////////////////////////////////////////////////////////////////////////
    // status frame codes
    ////////////////////////////////////////////////////////////////////////////

    localparam byte_t ST_REQUEST = 8'hA1;   // data request
    localparam byte_t ST_TIMEOUT = 8'hA2;   // experiment time-out
    localparam byte_t ST_ERROR   = 8'hA3;   // ephemeris error, top priority

endpackage

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // command opcodes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        OP_START_TIME = 8'h01,   // 8 payload bytes follow
        OP_DURATION   = 8'h02,   // 8 payload bytes follow
        OP_RUN        = 8'h04,
        OP_STOP       = 8'h05,
        OP_DOUBLE_ON  = 8'h0B,
        OP_DUO_ON     = 8'h0D,
        OP_DOUBLE_OFF = 8'h12,
        OP_DUO_OFF    = 8'h13,
        OP_STATIC_ON  = 8'h14,
        OP_STATIC_OFF = 8'h15,
        OP_RATE_1S    = 8'h16,
        OP_RATE_100MS = 8'h17,
        OP_RATE_10MS  = 8'h18,
        OP_RATE_1MS   = 8'h19,
        OP_RATE_OFF   = 8'h20
    } op_t;

    // telemetry rate codes
    typedef logic [2:0] rate_t;

    localparam rate_t RATE_OFF   = 3'd0;   // no telemetry
    localparam rate_t RATE_1S    = 3'd1;
    localparam rate_t RATE_100MS = 3'd2;
    localparam rate_t RATE_10MS  = 3'd3;
    localparam rate_t RATE_1MS   = 3'd4;

    ////////////////////////////////////////////////////////////////////////////
    // experiment mode
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  double_speed;
        logic  duo_pulsar;
        logic  running;
        logic  static_experiment;
        rate_t rate;
    } mode_t;

endpackage

`default_nettype wire

//--- hdl/byte_counter.sv
`default_nettype none

module byte_counter #(
    parameter int CNT_W = 4
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        clr,
    input  wire logic        inc,
    output logic [CNT_W-1:0] count
);

    // echo and payload byte index
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            count <= '0;
        else if (clr)
            count <= '0;   // clr wins over inc
        else if (inc)
            count <= count + CNT_W'(1);
    end

endmodule

`default_nettype wire

//--- hdl/frame_shifter.sv
`default_nettype none

module frame_shifter #(
    parameter int CNT_W = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire link_pkg::byte_t  rx_byte,
    input  wire logic             hdr_shift,
    input  wire logic             hdr_load,
    input  wire logic             pay_shift,
    input  wire logic             send,
    input  wire link_pkg::byte_t  status_code,
    input  wire logic [CNT_W-1:0] count,
    output logic                  sync_seen,
    output ctrl_pkg::op_t         opcode,
    output link_pkg::word_t       payload,
    output link_pkg::byte_t       tx_byte,
    output logic                  tx_valid
);
    import link_pkg::*;
    import ctrl_pkg::*;

    localparam int SEL_W = $clog2(HDR_BYTES);

    byte_t [HDR_BYTES-1:0]  hdr;   // [0] newest byte
    byte_t [WORD_BYTES-1:0] pay;
    logic  [SEL_W-1:0]      sel;

    ////////////////////////////////////////////////////////////////////////////
    // header window
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            hdr <= '0;
        else if (hdr_load)
            hdr <= {SYNC_HI, SYNC_LO, status_code};
        else if (hdr_shift)
            hdr <= {hdr[HDR_BYTES-2:0], rx_byte};
    end

    assign sync_seen = (hdr[HDR_BYTES-1] == SYNC_HI) && (hdr[HDR_BYTES-2] == SYNC_LO);
    assign opcode    = op_t'(hdr[0]);

    // first byte in ends up on top
    always_ff @(posedge clk)
    begin
        if (pay_shift)
            pay <= {pay[WORD_BYTES-2:0], rx_byte};
    end

    assign payload = pay;

    ////////////////////////////////////////////////////////////////////////////
    // outgoing byte
    ////////////////////////////////////////////////////////////////////////////

    assign sel = SEL_W'(HDR_BYTES - 1 - int'(count));   // byte 0 is the oldest

    always_ff @(posedge clk)
    begin
        if (send)
            tx_byte <= hdr[sel];
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            tx_valid <= 1'b0;
        else
            tx_valid <= send;   // one cycle strobe
    end

endmodule

`default_nettype wire

//--- hdl/frame_fsm.sv
`default_nettype none

module frame_fsm #(
    parameter int CNT_W = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             rx_valid,
    input  wire logic             tx_done,
    input  wire logic             request_data,
    input  wire logic             time_out,
    input  wire logic             eph_error,
    input  wire logic [CNT_W-1:0] count,
    input  wire logic             sync_seen,
    input  wire ctrl_pkg::op_t    opcode,
    output logic                  cnt_clr,
    output logic                  cnt_inc,
    output logic                  hdr_shift,
    output logic                  hdr_load,
    output logic                  pay_shift,
    output logic                  send,
    output logic                  apply,
    output logic                  load_word,
    output logic                  idle,
    output link_pkg::byte_t       status_code
);
    import link_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [2:0] {
        IDLE,      // hunting for sync
        CHECK,     // header window settled
        ARM,
        SEND,
        WAIT,      // byte on the serializer
        PAYLOAD,
        LOAD
    } state_t;

    state_t state;
    state_t state_nx;
    logic   status_req;
    logic   status_frame;   // current frame is a status frame
    logic   last_hdr;
    logic   last_pay;
    logic   is_word;

    assign status_req = request_data | time_out | eph_error;
    assign last_hdr   = (count == CNT_W'(HDR_BYTES - 1));
    assign last_pay   = (count == CNT_W'(WORD_BYTES - 1));
    assign is_word    = (opcode == OP_START_TIME) || (opcode == OP_DURATION);
    assign idle       = (state == IDLE);

    // error beats time-out beats request
    always_comb
    begin
        if (eph_error)
            status_code = ST_ERROR;
        else if (time_out)
            status_code = ST_TIMEOUT;
        else
            status_code = ST_REQUEST;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state        <= IDLE;
            status_frame <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            if (state == IDLE)
                status_frame <= status_req && !rx_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nx  = state;
        cnt_clr   = 1'b0;
        cnt_inc   = 1'b0;
        hdr_shift = 1'b0;
        hdr_load  = 1'b0;
        pay_shift = 1'b0;
        send      = 1'b0;
        apply     = 1'b0;
        load_word = 1'b0;
        case (state)
            IDLE:
            begin
                cnt_clr = 1'b1;
                if (rx_valid)
                begin
                    hdr_shift = 1'b1;
                    state_nx  = CHECK;
                end
                else if (status_req)
                begin
                    hdr_load = 1'b1;   // 00 FF code
                    state_nx = ARM;
                end
            end
            CHECK:
            begin
                if (sync_seen)
                    state_nx = ARM;
                else if (rx_valid)
                    hdr_shift = 1'b1;   // keep hunting
                else
                    state_nx = IDLE;
            end
            ARM:
                state_nx = SEND;
            SEND:
            begin
                send     = 1'b1;
                state_nx = WAIT;
            end
            WAIT:
            begin
                if (tx_done)
                begin
                    if (!last_hdr)
                    begin
                        cnt_inc  = 1'b1;
                        state_nx = SEND;
                    end
                    else if (status_frame)
                        state_nx = IDLE;
                    else if (is_word)
                    begin
                        cnt_clr  = 1'b1;
                        state_nx = PAYLOAD;
                    end
                    else
                    begin
                        apply    = 1'b1;
                        state_nx = IDLE;
                    end
                end
            end
            PAYLOAD:
            begin
                if (rx_valid)
                begin
                    pay_shift = 1'b1;
                    cnt_inc   = 1'b1;
                    if (last_pay)
                        state_nx = LOAD;
                end
            end
            LOAD:
            begin
                load_word = 1'b1;
                state_nx  = IDLE;
            end
            default:
                state_nx = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mode_regs.sv
`default_nettype none

module mode_regs (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            apply,
    input  wire logic            load_word,
    input  wire logic            idle,
    input  wire logic            exp_done,
    input  wire ctrl_pkg::op_t   opcode,
    input  wire link_pkg::word_t payload,
    output ctrl_pkg::mode_t      mode,
    output link_pkg::word_t      start_time,
    output link_pkg::word_t      exp_duration
);
    import ctrl_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // mode flags and rate
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            mode <= '0;
        else if (apply)
        begin
            case (opcode)
                OP_DOUBLE_ON:  mode.double_speed      <= 1'b1;
                OP_DOUBLE_OFF: mode.double_speed      <= 1'b0;
                OP_DUO_ON:     mode.duo_pulsar        <= 1'b1;
                OP_DUO_OFF:    mode.duo_pulsar        <= 1'b0;
                OP_RUN:        mode.running           <= 1'b1;
                OP_STOP:       mode.running           <= 1'b0;
                OP_STATIC_ON:  mode.static_experiment <= 1'b1;
                OP_STATIC_OFF: mode.static_experiment <= 1'b0;
                OP_RATE_1S:    mode.rate              <= RATE_1S;
                OP_RATE_100MS: mode.rate              <= RATE_100MS;
                OP_RATE_10MS:  mode.rate              <= RATE_10MS;
                OP_RATE_1MS:   mode.rate              <= RATE_1MS;
                OP_RATE_OFF:   mode.rate              <= RATE_OFF;
                default: ;   // unknown code
            endcase
        end
        else if (idle && exp_done)
            mode.running <= 1'b0;   // experiment finished
    end

    // parameter words
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            start_time   <= '0;
            exp_duration <= '0;
        end
        else if (load_word)
        begin
            if (opcode == OP_START_TIME)
                start_time <= payload;
            if (opcode == OP_DURATION)
                exp_duration <= payload;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ground_link.sv
`default_nettype none

module ground_link (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire link_pkg::byte_t rx_byte,
    input  wire logic            rx_valid,
    input  wire logic            tx_done,
    input  wire logic            request_data,
    input  wire logic            time_out,
    input  wire logic            eph_error,
    input  wire logic            exp_done,
    output link_pkg::byte_t      tx_byte,
    output logic                 tx_valid,
    output ctrl_pkg::mode_t      mode,
    output link_pkg::word_t      start_time,
    output link_pkg::word_t      exp_duration
);
    import link_pkg::*;
    import ctrl_pkg::*;

    localparam int CNT_W = 4;   // holds 0 to 8

    logic [CNT_W-1:0] count;
    logic             cnt_clr, cnt_inc;
    logic             hdr_shift, hdr_load, pay_shift, send;
    logic             apply, load_word, idle, sync_seen;
    op_t              opcode;
    word_t            payload;
    byte_t            status_code;

    frame_fsm #(.CNT_W(CNT_W)) i_frame_fsm (
        .clk, .rst, .rx_valid, .tx_done,
        .request_data, .time_out, .eph_error,
        .count, .sync_seen, .opcode,
        .cnt_clr, .cnt_inc, .hdr_shift, .hdr_load, .pay_shift, .send,
        .apply, .load_word, .idle, .status_code
    );

    byte_counter #(.CNT_W(CNT_W)) i_byte_counter (
        .clk, .rst,
        .clr   (cnt_clr),
        .inc   (cnt_inc),
        .count
    );

    frame_shifter #(.CNT_W(CNT_W)) i_frame_shifter (
        .clk, .rst, .rx_byte,
        .hdr_shift, .hdr_load, .pay_shift, .send,
        .status_code, .count,
        .sync_seen, .opcode, .payload, .tx_byte, .tx_valid
    );

    mode_regs i_mode_regs (
        .clk, .rst, .apply, .load_word, .idle, .exp_done,
        .opcode, .payload,
        .mode, .start_time, .exp_duration
    );

endmodule

`default_nettype wire

//--- tests/tb_ground_link.sv
`default_nettype none

module tb_ground_link;
    import link_pkg::*;
    import ctrl_pkg::*;

    localparam int CYCLES_PER_TEST = 2000;
    localparam int SETTLE          = 8;   // longer than the 2-cycle word update

    typedef struct packed {
        int         junk;    // non-sync bytes ahead of the frame
        byte_t      op;
        logic       pay_on;
        word_t      pay;
        logic [3:0] raise;   // exp_done, eph_error, time_out, request_data
        int         n_tx;
        byte_t      code;    // third byte coming back
        mode_t      mode;
        word_t      start;
        word_t      dur;
    } test_t;

    logic  clk;
    logic  rst;
    byte_t rx_byte;
    logic  rx_valid;
    logic  tx_done;
    logic  request_data;
    logic  time_out;
    logic  eph_error;
    logic  exp_done;
    byte_t tx_byte;
    logic  tx_valid;
    mode_t mode;
    word_t start_time;
    word_t exp_duration;

    test_t tests[$];
    byte_t seen[$];   // bytes taken by the serializer
    int    done_cnt;
    int    errors;
    int    n_fail;
    word_t pay;       // table build state
    word_t st;
    word_t du;

    ground_link i_ground_link (
        .clk, .rst, .rx_byte, .rx_valid, .tx_done,
        .request_data, .time_out, .eph_error, .exp_done,
        .tx_byte, .tx_valid, .mode, .start_time, .exp_duration
    );

    always #5 clk = ~clk;

    // serializer model
    always @(negedge clk)
    begin
        if (tx_valid)
        begin
            seen.push_back(tx_byte);
            repeat (2 + $urandom % 19) @(negedge clk);
            tx_done = 1'b1;
            done_cnt++;
            @(negedge clk);
            tx_done = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // PC side
    ////////////////////////////////////////////////////////////////////////////

    task automatic gap();
        repeat (1 + $urandom % 5) @(negedge clk);
    endtask

    task automatic send_byte(input byte_t b);
        rx_byte  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        gap();
    endtask

    task automatic wait_tx(input int n, output logic ok);
        int cycles;
        cycles = 0;
        while (done_cnt < n && cycles < CYCLES_PER_TEST)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (done_cnt >= n);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic mode_t mk_mode(input int ds, input int duo, input int run,
                                      input int stat, input int rate);
        mode_t m;
        m.double_speed      = (ds != 0);
        m.duo_pulsar        = (duo != 0);
        m.running           = (run != 0);
        m.static_experiment = (stat != 0);
        m.rate              = rate_t'(rate);
        return m;
    endfunction

    task automatic add_case(input int junk, input byte_t op, input logic pay_on,
                            input logic [3:0] raise, input int n_tx, input byte_t code,
                            input mode_t m);
        test_t t;
        t = '{junk, op, pay_on, pay, raise, n_tx, code, m, st, du};
        tests.push_back(t);
    endtask

    task automatic build_table();
        pay = '0;
        st  = '0;
        du  = '0;
        add_case(3, OP_DOUBLE_ON, 1'b0, 4'h0, 3, OP_DOUBLE_ON, mk_mode(1, 0, 0, 0, 0));
        add_case(0, OP_DUO_ON, 1'b0, 4'h0, 3, OP_DUO_ON, mk_mode(1, 1, 0, 0, 0));
        add_case(2, OP_RUN, 1'b0, 4'h0, 3, OP_RUN, mk_mode(1, 1, 1, 0, 0));
        add_case(1, OP_STATIC_ON, 1'b0, 4'h0, 3, OP_STATIC_ON, mk_mode(1, 1, 1, 1, 0));
        add_case(4, OP_RATE_1S, 1'b0, 4'h0, 3, OP_RATE_1S, mk_mode(1, 1, 1, 1, 1));
        add_case(0, OP_RATE_100MS, 1'b0, 4'h0, 3, OP_RATE_100MS, mk_mode(1, 1, 1, 1, 2));
        add_case(2, OP_RATE_10MS, 1'b0, 4'h0, 3, OP_RATE_10MS, mk_mode(1, 1, 1, 1, 3));
        add_case(1, OP_RATE_1MS, 1'b0, 4'h0, 3, OP_RATE_1MS, mk_mode(1, 1, 1, 1, 4));
        pay = {$urandom, $urandom};
        st  = pay;
        add_case(3, OP_START_TIME, 1'b1, 4'h0, 3, OP_START_TIME, mk_mode(1, 1, 1, 1, 4));
        pay = {$urandom, $urandom};
        du  = pay;
        add_case(0, OP_DURATION, 1'b1, 4'h0, 3, OP_DURATION, mk_mode(1, 1, 1, 1, 4));
        add_case(4, 8'h7E, 1'b0, 4'h0, 3, 8'h7E, mk_mode(1, 1, 1, 1, 4));   // unknown code
        // status frames, error over time-out over request
        add_case(0, 8'h00, 1'b0, 4'b0001, 3, ST_REQUEST, mk_mode(1, 1, 1, 1, 4));
        add_case(0, 8'h00, 1'b0, 4'b0010, 3, ST_TIMEOUT, mk_mode(1, 1, 1, 1, 4));
        add_case(0, 8'h00, 1'b0, 4'b0100, 3, ST_ERROR, mk_mode(1, 1, 1, 1, 4));
        add_case(0, 8'h00, 1'b0, 4'b0011, 3, ST_TIMEOUT, mk_mode(1, 1, 1, 1, 4));
        add_case(0, 8'h00, 1'b0, 4'b0111, 3, ST_ERROR, mk_mode(1, 1, 1, 1, 4));
        add_case(0, 8'h00, 1'b0, 4'b0101, 3, ST_ERROR, mk_mode(1, 1, 1, 1, 4));
        add_case(0, 8'h00, 1'b0, 4'b1000, 0, 8'h00, mk_mode(1, 1, 0, 1, 4));   // exp_done
        add_case(2, OP_DOUBLE_OFF, 1'b0, 4'h0, 3, OP_DOUBLE_OFF, mk_mode(0, 1, 0, 1, 4));
        add_case(1, OP_DUO_OFF, 1'b0, 4'h0, 3, OP_DUO_OFF, mk_mode(0, 0, 0, 1, 4));
        add_case(3, OP_STATIC_OFF, 1'b0, 4'h0, 3, OP_STATIC_OFF, mk_mode(0, 0, 0, 0, 4));
        add_case(0, OP_RATE_OFF, 1'b0, 4'h0, 3, OP_RATE_OFF, mk_mode(0, 0, 0, 0, 0));
        add_case(2, OP_RUN, 1'b0, 4'h0, 3, OP_RUN, mk_mode(0, 0, 1, 0, 0));
        pay = {$urandom, $urandom};
        st  = pay;
        add_case(1, OP_START_TIME, 1'b1, 4'h0, 3, OP_START_TIME, mk_mode(0, 0, 1, 0, 0));
        add_case(4, OP_STOP, 1'b0, 4'h0, 3, OP_STOP, mk_mode(0, 0, 0, 0, 0));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one table entry
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_case(input int idx);
        test_t t;
        logic  ok;
        int    errs_at_start;
        int    i;
        int    k;
        byte_t exp_b;
        t = tests[idx];
        errs_at_start = errors;
        seen.delete();
        done_cnt = 0;
        if (t.raise != 4'h0)
        begin
            {exp_done, eph_error, time_out, request_data} = t.raise;
            repeat (2) @(negedge clk);
            {exp_done, eph_error, time_out, request_data} = 4'h0;
        end
        else
        begin
            repeat (t.junk) send_byte(byte_t'(1 + $urandom % 254));   // never 00 or FF
            send_byte(SYNC_HI);
            send_byte(SYNC_LO);
            send_byte(t.op);
            if (t.pay_on)
            begin
                wait_tx(3, ok);   // echo must finish first
                gap();
                for (k = 0; k < WORD_BYTES; k++)
                    send_byte(t.pay[63 - 8*k -: 8]);   // msb first
            end
        end
        wait_tx(t.n_tx, ok);
        if (!ok)
        begin
            errors++;
            $display("case %0d: serializer got %0d of %0d bytes in time", idx, done_cnt, t.n_tx);
        end
        repeat (SETTLE) @(negedge clk);
        check("tx count", 64'(seen.size()), 64'(t.n_tx));
        for (i = 0; i < seen.size() && i < t.n_tx; i++)
        begin
            exp_b = (i == 0) ? SYNC_HI : (i == 1) ? SYNC_LO : t.code;
            check("tx_byte", 64'(seen[i]), 64'(exp_b));
        end
        check("mode", 64'(mode), 64'(t.mode));
        check("start_time", start_time, t.start);
        check("exp_duration", exp_duration, t.dur);
        if (errors == errs_at_start)
            $display("case %0d op %h raise %b: ok", idx, t.op, t.raise);
        else
        begin
            n_fail++;
            $display("case %0d op %h raise %b: FAIL", idx, t.op, t.raise);
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b0;
        rx_byte      = '0;
        rx_valid     = 1'b0;
        tx_done      = 1'b0;
        request_data = 1'b0;
        time_out     = 1'b0;
        eph_error    = 1'b0;
        exp_done     = 1'b0;
        done_cnt     = 0;
        errors       = 0;
        n_fail       = 0;
        void'($urandom(73656));
        build_table();
        repeat (4) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        foreach (tests[n])
            run_case(n);
        $display("cases %0d, failing %0d, errors %0d", tests.size(), n_fail, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog
    initial
    begin
        @(posedge rst);
        repeat (tests.size() * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired, run did not finish in %0d cycles",
                 tests.size() * CYCLES_PER_TEST);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/link_pkg.sv
hdl/ctrl_pkg.sv
hdl/byte_counter.sv
hdl/frame_shifter.sv
hdl/frame_fsm.sv
hdl/mode_regs.sv
hdl/ground_link.sv
tests/tb_ground_link.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_ground_link
RTL_TOP   = ground_link
FILELIST  = verilog.f
PASS_MSG  = test passed
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
